//--- src.f
i2c_pkg.sv
i2c_bit_timer.sv
i2c_fsm.sv
i2c_byte_shift.sv
i2c_line_drive.sv
i2c_master_top.sv
tb_i2c_slave.sv
tb_top.sv

//--- run.sh
#!/usr/bin/env bash
# build with verilator, run the simulation, judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module tb_top -f src.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Everything OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- tb_top.sv
module tb_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int     CLK_HALF_NS = 50;
    localparam int     MAX_XFERS   = 80;
    localparam int     MAX_BITS    = 48;    // read with 16-bit address
    localparam longint WATCHDOG_NS = longint'(MAX_XFERS * MAX_BITS + 200)
                                     * i2c_pkg::QUARTERS_PER_BIT * 2 * CLK_HALF_NS;

    logic                ctrl_clk;
    logic                rst_n;
    logic                i2c_exec;
    logic                bit_ctrl;
    logic                i2c_rh_wl;
    i2c_pkg::word_addr_t i2c_addr;
    i2c_pkg::data_t      i2c_data_w;
    i2c_pkg::data_t      i2c_data_r;
    logic                i2c_done;
    logic                scl;
    logic                sda_low;
    logic                sda_bus;
    logic                slave_pull;
    logic                slave_err;
    logic                slave_rd;
    logic                slave_wide;
    i2c_pkg::word_addr_t slave_addr;
    int                  start_cnt;
    int                  rstart_cnt;
    int                  stop_cnt;
    logic                started;
    i2c_pkg::data_t      model_mem [int];

    assign sda_bus = !(sda_low || slave_pull);    // pulled-up wire

    i2c_master_top i_dut (
        .ctrl_clk   (ctrl_clk),
        .rst_n      (rst_n),
        .i2c_exec   (i2c_exec),
        .bit_ctrl   (bit_ctrl),
        .i2c_rh_wl  (i2c_rh_wl),
        .i2c_addr   (i2c_addr),
        .i2c_data_w (i2c_data_w),
        .sda_in     (sda_bus),
        .i2c_data_r (i2c_data_r),
        .i2c_done   (i2c_done),
        .scl        (scl),
        .sda_low    (sda_low)
    );

    tb_i2c_slave u_slave (
        .ctrl_clk   (ctrl_clk),
        .rst_n      (rst_n),
        .scl        (scl),
        .sda        (sda_bus),
        .wide       (slave_wide),
        .exp_rd     (slave_rd),
        .exp_addr   (slave_addr),
        .sda_pull   (slave_pull),
        .err        (slave_err),
        .start_cnt  (start_cnt),
        .rstart_cnt (rstart_cnt),
        .stop_cnt   (stop_cnt)
    );

    always #CLK_HALF_NS ctrl_clk = ~ctrl_clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    always @(posedge slave_err) abort_run("bus protocol check in the slave model failed");

    initial begin
        #(WATCHDOG_NS);
        abort_run("watchdog expired before the test sequence finished");
    end

    a_idle_bus: assert property (@(posedge ctrl_clk) disable iff (!rst_n)
        !started |-> (scl && sda_bus && !i2c_done))
        else abort_run($sformatf("[FAIL] idle bus scl=%h sda=%h i2c_done=%h",
                                 scl, sda_bus, i2c_done));

    a_done_pulse: assert property (@(posedge ctrl_clk) disable iff (!rst_n)
        i2c_done |=> !i2c_done)
        else abort_run("i2c_done stayed high for more than one cycle");

    // bit times: start, dev_w, address bytes, then data or turnaround, stop
    function automatic int transfer_bits(input logic rd, input logic wide);
        int bits;
        bits = 2 + i2c_pkg::BITS_PER_BYTE_SEG * (wide ? 3 : 2);
        if (rd) begin
            bits = bits + 1 + 2 * i2c_pkg::BITS_PER_BYTE_SEG;
        end else begin
            bits = bits + i2c_pkg::BITS_PER_BYTE_SEG;
        end
        return bits;
    endfunction

    function automatic i2c_pkg::word_addr_t bus_addr(input logic wide,
                                                     input i2c_pkg::word_addr_t addr);
        return wide ? addr : {8'h00, addr[7:0]};
    endfunction

    task automatic run_transfer(input logic rd, input logic wide,
                                input i2c_pkg::word_addr_t addr, input i2c_pkg::data_t wd,
                                input int inject_at, output i2c_pkg::data_t rdata);
        int cycles;
        int limit;
        int starts0;
        int rstarts0;
        int stops0;
        logic inject;
        limit    = transfer_bits(rd, wide) * i2c_pkg::QUARTERS_PER_BIT;
        starts0  = start_cnt;
        rstarts0 = rstart_cnt;
        stops0   = stop_cnt;
        @(negedge ctrl_clk);
        i2c_exec   = 1'b1;
        i2c_rh_wl  = rd;
        bit_ctrl   = wide;
        i2c_addr   = addr;
        i2c_data_w = wd;
        slave_rd   = rd;
        slave_wide = wide;
        slave_addr = bus_addr(wide, addr);
        started    = 1'b1;
        cycles     = -1;    // first falling edge trails the accepting edge
        do begin
            @(negedge ctrl_clk);
            cycles++;
            inject   = (inject_at > 0) && (cycles == inject_at);
            i2c_exec = inject;
            if (inject) begin
                i2c_addr   = ~addr;    // conflicting write, must be dropped
                i2c_data_w = ~wd;
            end
            assert (cycles <= limit) else abort_run("i2c_done did not arrive in time");
        end while (!i2c_done);
        rdata = i2c_data_r;
        assert (cycles == limit)
            else abort_run($sformatf("[FAIL] done_latency got %h exp %h", cycles, limit));
        assert (start_cnt == starts0 + 1 && stop_cnt == stops0 + 1)
            else abort_run($sformatf("[FAIL] start_cnt/stop_cnt got %h/%h exp %h/%h",
                                     start_cnt - starts0, stop_cnt - stops0, 1, 1));
        assert (rstart_cnt == rstarts0 + int'(rd))
            else abort_run($sformatf("[FAIL] rstart_cnt got %h exp %h",
                                     rstart_cnt - rstarts0, rd));
    endtask

    task automatic read_and_check(input logic wide, input i2c_pkg::word_addr_t addr);
        i2c_pkg::data_t got;
        i2c_pkg::data_t exp;
        run_transfer(1'b1, wide, addr, 8'h00, 0, got);
        exp = model_mem[int'(bus_addr(wide, addr))];
        assert (got == exp)
            else abort_run($sformatf("[FAIL] i2c_data_r got %h exp %h", got, exp));
    endtask

    task automatic write_then_read(input logic wide, input i2c_pkg::word_addr_t addr,
                                   input i2c_pkg::data_t wd);
        i2c_pkg::data_t unused;
        run_transfer(1'b0, wide, addr, wd, 0, unused);
        model_mem[int'(bus_addr(wide, addr))] = wd;
        read_and_check(wide, addr);
    endtask

    //**************************************************
    // stimulus
    //**************************************************
    initial begin
        i2c_pkg::data_t unused;
        ctrl_clk   = 1'b0;
        rst_n      = 1'b0;
        i2c_exec   = 1'b0;
        bit_ctrl   = 1'b0;
        i2c_rh_wl  = 1'b0;
        i2c_addr   = '0;
        i2c_data_w = '0;
        slave_rd   = 1'b0;
        slave_wide = 1'b0;
        slave_addr = '0;
        started    = 1'b0;
        void'($urandom(96));
        repeat (4) @(negedge ctrl_clk);
        rst_n = 1'b1;
        repeat (12) @(negedge ctrl_clk);    // idle bus after reset
        for (int w = 0; w < 2; w++) begin
            for (int n = 0; n < 16; n++) begin
                write_then_read(w[0], 16'($urandom), 8'($urandom));
            end
        end
        // strobe mid write, aimed at a byte already stored
        write_then_read(1'b1, ~16'h1234, 8'h66);
        run_transfer(1'b0, 1'b1, 16'h1234, 8'h3c, 60, unused);
        model_mem[int'(16'h1234)] = 8'h3c;
        read_and_check(1'b1, ~16'h1234);
        read_and_check(1'b1, 16'h1234);
        $display("Everything OK");
        $finish;
    end

endmodule

//--- tb_i2c_slave.sv
module tb_i2c_slave (
    input  logic                ctrl_clk,
    input  logic                rst_n,
    input  logic                scl,
    input  logic                sda,
    input  logic                wide,
    input  logic                exp_rd,
    input  i2c_pkg::word_addr_t exp_addr,
    output logic                sda_pull,
    output logic                err,
    output int                  start_cnt,
    output int                  rstart_cnt,
    output int                  stop_cnt
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [7:0]          mem [0:65535];
    logic                scl_q;
    logic                sda_q;
    logic                in_xfer;
    logic                skip_fall;     // scl fall that closes a start
    logic                rd_mode;
    logic                sending;
    logic                rstart_seen;
    logic                nack_seen;
    int                  bit_cnt;
    int                  byte_no;
    int                  addr_bytes;
    int                  data_cnt;
    int                  need;
    i2c_pkg::data_t      sh;
    i2c_pkg::data_t      tx;
    i2c_pkg::word_addr_t addr;

    assign need = wide ? 2 : 1;

    initial begin
        for (int i = 0; i < 65536; i++) begin
            mem[i] <= 8'(i) ^ 8'(i >> 8) ^ 8'h5a;
        end
    end

    task automatic report_error(input string msg);
        $display("%s", msg);
        err <= 1'b1;
    endtask

    always @(posedge ctrl_clk or negedge rst_n) begin
        if (!rst_n) begin
            scl_q       <= 1'b1;
            sda_q       <= 1'b1;
            in_xfer     <= 1'b0;
            skip_fall   <= 1'b0;
            rd_mode     <= 1'b0;
            sending     <= 1'b0;
            rstart_seen <= 1'b0;
            nack_seen   <= 1'b0;
            bit_cnt     <= 0;
            byte_no     <= 0;
            addr_bytes  <= 0;
            data_cnt    <= 0;
            sh          <= '0;
            tx          <= '0;
            addr        <= '0;
            sda_pull    <= 1'b0;
            err         <= 1'b0;
            start_cnt   <= 0;
            rstart_cnt  <= 0;
            stop_cnt    <= 0;
        end else begin
            scl_q <= scl;
            sda_q <= sda;
            //**************************************************
            // bus conditions, sda moving under high scl
            //**************************************************
            if (scl_q && scl && sda_q && !sda) begin
                assert (bit_cnt == 0) else report_error("START seen inside a byte");
                if (in_xfer) begin
                    assert (exp_rd && addr_bytes == need && data_cnt == 0)
                        else report_error("repeated START outside a read turnaround");
                    rstart_cnt  <= rstart_cnt + 1;
                    rstart_seen <= 1'b1;
                end else begin
                    start_cnt   <= start_cnt + 1;
                    addr        <= '0;
                    addr_bytes  <= 0;
                    data_cnt    <= 0;
                    rstart_seen <= 1'b0;
                    rd_mode     <= 1'b0;
                    sending     <= 1'b0;
                    nack_seen   <= 1'b0;
                end
                in_xfer   <= 1'b1;
                byte_no   <= 0;
                bit_cnt   <= 0;
                skip_fall <= 1'b1;
            end else if (scl_q && scl && !sda_q && sda) begin
                assert (in_xfer && bit_cnt == 0)
                    else report_error("STOP seen inside a byte or outside a transfer");
                assert (addr_bytes == need)
                    else report_error($sformatf("[FAIL] addr_bytes got %h exp %h",
                                                addr_bytes, need));
                assert (addr == exp_addr)
                    else report_error($sformatf("[FAIL] word_addr got %h exp %h",
                                                addr, exp_addr));
                if (exp_rd) begin
                    assert (rstart_seen && nack_seen)
                        else report_error("read ended without repeated START or master NACK");
                end else begin
                    assert (data_cnt == 1 && !rstart_seen)
                        else report_error($sformatf("[FAIL] data_cnt got %h exp %h",
                                                    data_cnt, 1));
                end
                stop_cnt <= stop_cnt + 1;
                in_xfer  <= 1'b0;
                sda_pull <= 1'b0;
            end else if (in_xfer && !scl_q && scl) begin
                if (bit_cnt < 8) begin
                    sh <= {sh[6:0], sda};
                end else if (sending) begin
                    nack_seen <= sda;    // released line is the nack
                end
            end else if (in_xfer && scl_q && !scl) begin
                if (skip_fall) begin
                    skip_fall <= 1'b0;
                end else if (bit_cnt == 7) begin
                    bit_cnt  <= 8;
                    sda_pull <= !sending;    // ack what we received
                    if (!sending) begin
                        if (byte_no == 0) begin
                            assert (sh[7:1] == i2c_pkg::SLAVE_ADDR)
                                else report_error($sformatf("[FAIL] dev_addr got %h exp %h",
                                                            sh[7:1], i2c_pkg::SLAVE_ADDR));
                            assert (sh[0] == rstart_seen)
                                else report_error($sformatf("[FAIL] rw_bit got %h exp %h",
                                                            sh[0], rstart_seen));
                            rd_mode <= sh[0];
                        end else if (addr_bytes < need) begin
                            addr       <= {addr[7:0], sh};
                            addr_bytes <= addr_bytes + 1;
                        end else begin
                            mem[addr] <= sh;
                            data_cnt  <= data_cnt + 1;
                        end
                        byte_no <= byte_no + 1;
                    end
                end else if (bit_cnt == 8) begin
                    bit_cnt <= 0;
                    if (rd_mode && !sending) begin
                        sending  <= 1'b1;
                        tx       <= mem[addr];
                        sda_pull <= !mem[addr][7];
                    end else begin
                        sending  <= 1'b0;
                        sda_pull <= 1'b0;
                    end
                end else begin
                    bit_cnt <= bit_cnt + 1;
                    if (sending) begin
                        sda_pull <= !tx[3'(6 - bit_cnt)];
                    end
                end
            end
        end
    end

endmodule

//--- i2c_master_top.sv
module i2c_master_top (
    input  logic                ctrl_clk,
    input  logic                rst_n,
    input  logic                i2c_exec,
    input  logic                bit_ctrl,
    input  logic                i2c_rh_wl,
    input  i2c_pkg::word_addr_t i2c_addr,
    input  i2c_pkg::data_t      i2c_data_w,
    input  logic                sda_in,
    output i2c_pkg::data_t      i2c_data_r,
    output logic                i2c_done,
    output logic                scl,
    output logic                sda_low
);

    i2c_pkg::seg_t      seg;
    i2c_pkg::byte_sel_t byte_sel;
    i2c_pkg::quarter_t  quarter;
    i2c_pkg::bit_idx_t  bit_idx;
    logic               run;
    logic               req_start;
    logic               seg_end;
    logic               tx_bit;

    i2c_fsm u_fsm (
        .ctrl_clk  (ctrl_clk),
        .rst_n     (rst_n),
        .i2c_exec  (i2c_exec),
        .bit_ctrl  (bit_ctrl),
        .i2c_rh_wl (i2c_rh_wl),
        .seg_end   (seg_end),
        .seg       (seg),
        .byte_sel  (byte_sel),
        .run       (run),
        .req_start (req_start),
        .i2c_done  (i2c_done)
    );

    i2c_bit_timer u_timer (
        .ctrl_clk (ctrl_clk),
        .rst_n    (rst_n),
        .run      (run),
        .seg      (seg),
        .quarter  (quarter),
        .bit_idx  (bit_idx),
        .seg_end  (seg_end)
    );

    i2c_byte_shift u_shift (
        .ctrl_clk   (ctrl_clk),
        .rst_n      (rst_n),
        .req_start  (req_start),
        .byte_sel   (byte_sel),
        .seg        (seg),
        .quarter    (quarter),
        .bit_idx    (bit_idx),
        .sda_in     (sda_in),
        .i2c_addr   (i2c_addr),
        .i2c_data_w (i2c_data_w),
        .tx_bit     (tx_bit),
        .i2c_data_r (i2c_data_r)
    );

    i2c_line_drive u_line (
        .ctrl_clk (ctrl_clk),
        .rst_n    (rst_n),
        .seg      (seg),
        .byte_sel (byte_sel),
        .quarter  (quarter),
        .bit_idx  (bit_idx),
        .tx_bit   (tx_bit),
        .scl      (scl),
        .sda_low  (sda_low)
    );

endmodule

//--- i2c_line_drive.sv
module i2c_line_drive (
    input  logic               ctrl_clk,
    input  logic               rst_n,
    input  i2c_pkg::seg_t      seg,
    input  i2c_pkg::byte_sel_t byte_sel,
    input  i2c_pkg::quarter_t  quarter,
    input  i2c_pkg::bit_idx_t  bit_idx,
    input  logic               tx_bit,
    output logic               scl,
    output logic               sda_low
);

    logic scl_nxt;
    logic pull_nxt;
    logic sda_rel;

    // ack slot and every rdata bit belong to the slave, ninth rdata bit is the nack
    assign sda_rel = (bit_idx == i2c_pkg::bit_idx_t'(i2c_pkg::BITS_PER_BYTE_SEG - 1)) ||
                     (byte_sel == i2c_pkg::SEL_RDATA);

    //**************************************************
    // per quarter levels of each segment kind
    //**************************************************
    always_comb begin
        case (seg)
            i2c_pkg::SEG_START: begin
                scl_nxt  = (quarter != 2'd3);
                pull_nxt = (quarter != 2'd0);     // sda falls under high scl
            end
            i2c_pkg::SEG_BYTE: begin
                scl_nxt  = (quarter == 2'd1) || (quarter == 2'd2);
                pull_nxt = !sda_rel && !tx_bit;
            end
            i2c_pkg::SEG_RSTART: begin
                scl_nxt  = (quarter == 2'd1) || (quarter == 2'd2);
                pull_nxt = (quarter >= 2'd2);
            end
            i2c_pkg::SEG_STOP: begin
                scl_nxt  = (quarter != 2'd0);
                pull_nxt = (quarter < 2'd2);      // sda rises under high scl
            end
            default: begin
                scl_nxt  = 1'b1;                  // bus free
                pull_nxt = 1'b0;
            end
        endcase
    end

    always_ff @(posedge ctrl_clk or negedge rst_n) begin
        if (!rst_n) begin
            scl     <= 1'b1;
            sda_low <= 1'b0;
        end else begin
            scl     <= scl_nxt;
            sda_low <= pull_nxt;
        end
    end

    a_sda_stable: assert property (@(posedge ctrl_clk) disable iff (!rst_n)
        ($past(seg) == i2c_pkg::SEG_BYTE && $changed(sda_low)) |-> (!scl && !$past(scl)));

endmodule

//--- i2c_byte_shift.sv
module i2c_byte_shift (
    input  logic                  ctrl_clk,
    input  logic                  rst_n,
    input  logic                  req_start,
    input  i2c_pkg::byte_sel_t    byte_sel,
    input  i2c_pkg::seg_t         seg,
    input  i2c_pkg::quarter_t     quarter,
    input  i2c_pkg::bit_idx_t     bit_idx,
    input  logic                  sda_in,
    input  i2c_pkg::word_addr_t   i2c_addr,
    input  i2c_pkg::data_t        i2c_data_w,
    output logic                  tx_bit,
    output i2c_pkg::data_t        i2c_data_r
);

    i2c_pkg::word_addr_t addr_q;
    i2c_pkg::data_t      wdata_q;
    i2c_pkg::data_t      tx_byte;
    i2c_pkg::data_t      rx_sr;
    logic                in_rdata;
    logic                ack_slot;
    logic                rd_pend;   // read byte waiting for stop

    assign in_rdata = (seg == i2c_pkg::SEG_BYTE) && (byte_sel == i2c_pkg::SEL_RDATA);
    assign ack_slot = (bit_idx == i2c_pkg::bit_idx_t'(i2c_pkg::BITS_PER_BYTE_SEG - 1));

    always_ff @(posedge ctrl_clk) begin
        if (req_start) begin
            addr_q  <= i2c_addr;
            wdata_q <= i2c_data_w;
        end
        if (in_rdata && !ack_slot && quarter == 2'd2) begin
            rx_sr <= {rx_sr[6:0], sda_in};  // msb first, sampled mid scl high
        end
    end

    always_comb begin
        case (byte_sel)
            i2c_pkg::SEL_DEV_W:   tx_byte = {i2c_pkg::SLAVE_ADDR, 1'b0};
            i2c_pkg::SEL_ADDR_HI: tx_byte = addr_q[15:8];
            i2c_pkg::SEL_ADDR_LO: tx_byte = addr_q[7:0];
            i2c_pkg::SEL_WDATA:   tx_byte = wdata_q;
            i2c_pkg::SEL_DEV_R:   tx_byte = {i2c_pkg::SLAVE_ADDR, 1'b1};
            default:              tx_byte = 8'hff;  // rdata, line released
        endcase
    end

    assign tx_bit = tx_byte[3'd7 - bit_idx[2:0]];

    // hand the byte over together with i2c_done
    always_ff @(posedge ctrl_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_pend    <= 1'b0;
            i2c_data_r <= '0;
        end else if (in_rdata && ack_slot && quarter == 2'd3) begin
            rd_pend <= 1'b1;
        end else if (rd_pend && seg == i2c_pkg::SEG_STOP && quarter == 2'd3) begin
            rd_pend    <= 1'b0;
            i2c_data_r <= rx_sr;
        end
    end

endmodule

//--- i2c_fsm.sv
module i2c_fsm (
    input  logic               ctrl_clk,
    input  logic               rst_n,
    input  logic               i2c_exec,
    input  logic               bit_ctrl,
    input  logic               i2c_rh_wl,
    input  logic               seg_end,
    output i2c_pkg::seg_t      seg,
    output i2c_pkg::byte_sel_t byte_sel,
    output logic               run,
    output logic               req_start,
    output logic               i2c_done
);

    logic rd_flag;      // 1 = random read
    logic wide_flag;    // 1 = 16-bit word address

    assign run       = (seg != i2c_pkg::SEG_IDLE);
    assign req_start = (seg == i2c_pkg::SEG_IDLE) && i2c_exec;

    //**************************************************
    // sequence: start, dev_w, [addr_hi], addr_lo,
    // wdata | rstart dev_r rdata, stop
    //**************************************************
    always_ff @(posedge ctrl_clk or negedge rst_n) begin
        if (!rst_n) begin
            seg       <= i2c_pkg::SEG_IDLE;
            byte_sel  <= i2c_pkg::SEL_DEV_W;
            rd_flag   <= 1'b0;
            wide_flag <= 1'b0;
            i2c_done  <= 1'b0;
        end else begin
            i2c_done <= 1'b0;
            if (req_start) begin
                seg       <= i2c_pkg::SEG_START;
                byte_sel  <= i2c_pkg::SEL_DEV_W;
                rd_flag   <= i2c_rh_wl;
                wide_flag <= bit_ctrl;
            end else if (seg_end) begin
                case (seg)
                    i2c_pkg::SEG_START: begin
                        seg      <= i2c_pkg::SEG_BYTE;
                        byte_sel <= i2c_pkg::SEL_DEV_W;
                    end
                    i2c_pkg::SEG_RSTART: begin
                        seg      <= i2c_pkg::SEG_BYTE;
                        byte_sel <= i2c_pkg::SEL_DEV_R;
                    end
                    i2c_pkg::SEG_STOP: begin
                        seg      <= i2c_pkg::SEG_IDLE;
                        i2c_done <= 1'b1;
                    end
                    i2c_pkg::SEG_BYTE: begin
                        case (byte_sel)
                            i2c_pkg::SEL_DEV_W: begin
                                byte_sel <= wide_flag ? i2c_pkg::SEL_ADDR_HI
                                                      : i2c_pkg::SEL_ADDR_LO;
                            end
                            i2c_pkg::SEL_ADDR_HI: begin
                                byte_sel <= i2c_pkg::SEL_ADDR_LO;
                            end
                            i2c_pkg::SEL_ADDR_LO: begin
                                if (rd_flag) begin
                                    seg <= i2c_pkg::SEG_RSTART;  // turn bus around
                                end else begin
                                    byte_sel <= i2c_pkg::SEL_WDATA;
                                end
                            end
                            i2c_pkg::SEL_DEV_R: begin
                                byte_sel <= i2c_pkg::SEL_RDATA;
                            end
                            default: begin
                                seg <= i2c_pkg::SEG_STOP;  // wdata or rdata done
                            end
                        endcase
                    end
                    default: begin
                        seg <= i2c_pkg::SEG_IDLE;
                    end
                endcase
            end
        end
    end

    a_done_single: assert property (@(posedge ctrl_clk) disable iff (!rst_n)
        i2c_done |=> !i2c_done);

endmodule

//--- i2c_bit_timer.sv
module i2c_bit_timer (
    input  logic              ctrl_clk,
    input  logic              rst_n,
    input  logic              run,
    input  i2c_pkg::seg_t     seg,
    output i2c_pkg::quarter_t quarter,
    output i2c_pkg::bit_idx_t bit_idx,
    output logic              seg_end
);

    i2c_pkg::bit_idx_t seg_last;    // index of final bit in this segment
    logic              last_q;

    assign seg_last = (seg == i2c_pkg::SEG_BYTE) ?
                      i2c_pkg::bit_idx_t'(i2c_pkg::BITS_PER_BYTE_SEG - 1) : '0;
    assign last_q   = (quarter == i2c_pkg::quarter_t'(i2c_pkg::QUARTERS_PER_BIT - 1));
    assign seg_end  = run && last_q && (bit_idx == seg_last);

    always_ff @(posedge ctrl_clk or negedge rst_n) begin
        if (!rst_n) begin
            quarter <= '0;
            bit_idx <= '0;
        end else if (!run) begin
            quarter <= '0;  // parked while idle
            bit_idx <= '0;
        end else if (last_q) begin
            quarter <= '0;
            bit_idx <= seg_end ? '0 : bit_idx + 1'b1;
        end else begin
            quarter <= quarter + 1'b1;
        end
    end

    // fsm must swap seg exactly when the counters wrap
    a_bit_in_range: assert property (@(posedge ctrl_clk) disable iff (!rst_n)
        run |-> bit_idx <= seg_last);

endmodule

//--- i2c_pkg.sv
package i2c_pkg;

    //**************************************************
    // bus timing
    //**************************************************
    localparam int QUARTERS_PER_BIT  = 4;     // ctrl_clk cycles per scl bit
    localparam int BITS_PER_BYTE_SEG = 9;     // 8 data bits + ack slot

    localparam logic [6:0] SLAVE_ADDR = 7'h50; // eeprom style device address

    //**************************************************
    // types
    //**************************************************
    typedef logic [1:0]  quarter_t;
    typedef logic [3:0]  bit_idx_t;
    typedef logic [15:0] word_addr_t;
    typedef logic [7:0]  data_t;

    // what the bus is doing right now
    typedef enum logic [2:0] {
        SEG_IDLE   = 3'd0,
        SEG_START  = 3'd1,
        SEG_BYTE   = 3'd2,
        SEG_RSTART = 3'd3,
        SEG_STOP   = 3'd4
    } seg_t;

    // payload of a byte segment
    typedef enum logic [2:0] {
        SEL_DEV_W   = 3'd0,
        SEL_ADDR_HI = 3'd1,
        SEL_ADDR_LO = 3'd2,
        SEL_WDATA   = 3'd3,
        SEL_DEV_R   = 3'd4,
        SEL_RDATA   = 3'd5
    } byte_sel_t;

endpackage
